//--- Makefile
VERILATOR ?= verilator
TOP := tb_decode_issue
FILELIST := src.f
FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- hw/decode_issue_top.sv
////////////////////////////////////////////////////////////
// Decode and issue stage top level
// Decoder, per-unit issue ports, issue control, operand path
////////////////////////////////////////////////////////////
`default_nettype none

module decode_issue_top (
    input logic clk,
    input logic rst,

    // Decode handshake
    input logic decode_valid,
    input issue_pkg::instr_t decode_instruction,
    input issue_pkg::xlen_t decode_pc,
    input issue_pkg::id_t decode_id,
    output logic decode_advance,

    // Register file and scoreboard
    output issue_pkg::reg_addr_t rs1_addr,
    output issue_pkg::reg_addr_t rs2_addr,
    input issue_pkg::xlen_t rs1_data,
    input issue_pkg::xlen_t rs2_data,
    input logic rs1_busy,
    input logic rs2_busy,

    // Units
    input issue_pkg::unit_mask_t unit_ready,
    output issue_pkg::unit_mask_t new_request,
    output issue_pkg::id_t issue_id,
    output logic instruction_issued,
    output issue_pkg::xlen_t issue_pc,
    output issue_pkg::fn3_t issue_fn3,

    input logic issue_hold,
    input logic flush,

    // Operands
    output issue_pkg::xlen_t alu_in1,
    output issue_pkg::xlen_t alu_in2,
    output logic alu_subtract,
    output issue_pkg::alu_logic_op_t alu_logic_op,
    output issue_pkg::pc_offset_t branch_pc_offset,
    output issue_pkg::ls_offset_t ls_offset,
    output logic ls_store,
    output logic ls_forward
);
    import issue_pkg::*;

    unit_mask_t blocks;

    issue_stage_if stage_if ();

    decode_stage decode_i (
        .clk(clk),
        .rst(rst),
        .decode_instruction(decode_instruction),
        .decode_pc(decode_pc),
        .decode_id(decode_id),
        .decode_valid(decode_valid),
        .stage(stage_if.stage)
    );

    ////////////////////////////////////////////////////////////
    // One issue check per unit
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_port
        unit_issue_port #(
            .UNIT_INDEX(u),
            .NEEDS_RS2((u == LS_UNIT) ? 1'b0 : 1'b1)
        ) port_i (
            .clk(clk),
            .rst(rst),
            .stage(stage_if.sink),
            .ready(unit_ready[u]),
            .rs1_busy(rs1_busy),
            .rs2_busy(rs2_busy),
            .blocks(blocks[u])
        );
    end

    issue_control control_i (
        .clk(clk),
        .rst(rst),
        .issue_hold(issue_hold),
        .flush(flush),
        .stage(stage_if.sink),
        .decode_valid(decode_valid),
        .blocks(blocks),
        .decode_advance(decode_advance),
        .new_request(new_request),
        .issue_id(issue_id),
        .instruction_issued(instruction_issued)
    );

    operand_mux operands_i (
        .clk(clk),
        .decode_instruction(decode_instruction),
        .decode_pc(decode_pc),
        .stage(stage_if.sink),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs2_busy(rs2_busy),
        .alu_in1(alu_in1),
        .alu_in2(alu_in2),
        .alu_subtract(alu_subtract),
        .alu_logic_op(alu_logic_op),
        .branch_pc_offset(branch_pc_offset),
        .ls_offset(ls_offset),
        .ls_store(ls_store),
        .ls_forward(ls_forward)
    );

    // Register file reads straight from the stage
    assign rs1_addr = stage_if.rs1_addr;
    assign rs2_addr = stage_if.rs2_addr;
    assign issue_pc = stage_if.pc;
    assign issue_fn3 = stage_if.fn3;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
////////////////////////////////////////////////////////////
// Instruction decoder and one-entry issue-stage register
// Field split, register usage flags and unit selection
////////////////////////////////////////////////////////////
`default_nettype none

module decode_stage (
    input logic clk,
    input logic rst,

    input issue_pkg::instr_t decode_instruction,
    input issue_pkg::xlen_t decode_pc,
    input issue_pkg::id_t decode_id,
    input logic decode_valid,

    issue_stage_if.stage stage
);
    import issue_pkg::*;

    opcode_class_t opcode_class;
    fn3_t fn3;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    logic uses_rs1;
    logic uses_rs2;
    logic is_store;
    logic mul_div_op;
    unit_mask_t needed;

    ////////////////////////////////////////////////////////////
    // Field split
    assign opcode_class = decode_instruction[6:2];
    assign fn3 = decode_instruction[14:12];
    assign rs1_addr = decode_instruction[19:15];
    assign rs2_addr = decode_instruction[24:20];

    // OP with bit 25 set is M-extension
    assign mul_div_op = (opcode_class == OP_C) && decode_instruction[25];

    ////////////////////////////////////////////////////////////
    // Register usage
    always_comb begin
        uses_rs1 = 1'b1;
        if (opcode_class inside {LUI_C, AUIPC_C, JAL_C}) begin
            uses_rs1 = 1'b0;
        end
    end

    assign uses_rs2 = opcode_class inside {BRANCH_C, STORE_C, OP_C};
    assign is_store = (opcode_class == STORE_C);

    ////////////////////////////////////////////////////////////
    // Unit selection
    always_comb begin
        needed = '0;
        needed[BRANCH_UNIT] = opcode_class inside {BRANCH_C, JAL_C, JALR_C};

        // Jumps also write the link address through the ALU
        needed[ALU_UNIT] = ((opcode_class == OP_C) && !mul_div_op) ||
                           (opcode_class inside {OP_IMM_C, AUIPC_C, LUI_C, JAL_C, JALR_C});

        needed[LS_UNIT] = opcode_class inside {LOAD_C, STORE_C};
    end

    ////////////////////////////////////////////////////////////
    // Issue-stage register
    always_ff @(posedge clk) begin
        if (rst || stage.flush) begin
            stage.stage_valid <= 1'b0;
        end else if (stage.load) begin
            stage.stage_valid <= decode_valid;
        end
    end

    // Payload follows the same capture strobe
    always_ff @(posedge clk) begin
        if (stage.load) begin
            stage.needed <= needed;
            stage.uses_rs1 <= uses_rs1;
            stage.uses_rs2 <= uses_rs2;
            stage.rs1_addr <= rs1_addr;
            stage.rs2_addr <= rs2_addr;
            stage.is_store <= is_store;
            stage.id <= decode_id;
            stage.pc <= decode_pc;
            stage.fn3 <= fn3;
        end
    end

endmodule

`default_nettype wire

//--- hw/issue_control.sv
////////////////////////////////////////////////////////////
// Issue decision, request pulses and stage load control
////////////////////////////////////////////////////////////
`default_nettype none

module issue_control (
    input logic clk,
    input logic rst,
    input logic issue_hold,
    input logic flush,

    issue_stage_if.sink stage,

    input logic decode_valid,
    input issue_pkg::unit_mask_t blocks,

    output logic decode_advance,
    output issue_pkg::unit_mask_t new_request,
    output issue_pkg::id_t issue_id,
    output logic instruction_issued
);
    import issue_pkg::*;

    logic issue;
    logic load;
    issue_state_t state_q;

    ////////////////////////////////////////////////////////////
    // Issue and advance
    // No-unit instructions have no blocker and retire right away
    assign issue = stage.stage_valid && !issue_hold && !flush && !(|blocks);

    assign new_request = issue ? stage.needed : '0;
    assign instruction_issued = issue;
    assign issue_id = stage.id;

    // Flush wins over a new capture
    assign load = !issue_hold && !flush && (!stage.stage_valid || issue);
    assign decode_advance = decode_valid && load;

    assign stage.load = load;
    assign stage.flush = flush;

    // Occupancy tracked here against the decoder's valid bit
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state_q <= STAGE_EMPTY;
        end else if (load) begin
            state_q <= decode_valid ? STAGE_FULL : STAGE_EMPTY;
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    occupancy_matches: assert property (@(posedge clk) disable iff (rst)
        (state_q == STAGE_FULL) == stage.stage_valid)
        else $error("issue-stage occupancy mismatch");

    no_overwrite: assert property (@(posedge clk) disable iff (rst)
        (state_q == STAGE_FULL && stage.load) |-> instruction_issued)
        else $error("full stage loaded without issue");

endmodule

`default_nettype wire

//--- hw/issue_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and constants for the decode and issue stage
// Opcode classes, funct3 codes, unit indices, ALU logic ops
////////////////////////////////////////////////////////////
`default_nettype none

package issue_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    localparam int XLEN = 32;
    localparam int ID_WIDTH = 4;
    localparam int NUM_UNITS = 3;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [ID_WIDTH-1:0] id_t;
    typedef logic [4:0] opcode_class_t;
    typedef logic [2:0] fn3_t;
    typedef logic [20:0] pc_offset_t;
    typedef logic [11:0] ls_offset_t;
    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    ////////////////////////////////////////////////////////////
    // Opcode classes, bits 6:2 of the opcode
    localparam opcode_class_t LOAD_C = 5'b00000;
    localparam opcode_class_t FENCE_C = 5'b00011;
    localparam opcode_class_t OP_IMM_C = 5'b00100;
    localparam opcode_class_t AUIPC_C = 5'b00101;
    localparam opcode_class_t STORE_C = 5'b01000;
    localparam opcode_class_t OP_C = 5'b01100;
    localparam opcode_class_t LUI_C = 5'b01101;
    localparam opcode_class_t BRANCH_C = 5'b11000;
    localparam opcode_class_t JALR_C = 5'b11001;
    localparam opcode_class_t JAL_C = 5'b11011;
    localparam opcode_class_t SYSTEM_C = 5'b11100;

    // Integer funct3 codes
    localparam fn3_t ADD_SUB_F3 = 3'b000;
    localparam fn3_t SLT_F3 = 3'b010;
    localparam fn3_t SLTU_F3 = 3'b011;
    localparam fn3_t XOR_F3 = 3'b100;
    localparam fn3_t OR_F3 = 3'b110;
    localparam fn3_t AND_F3 = 3'b111;

    ////////////////////////////////////////////////////////////
    // Execution unit positions in a unit mask
    localparam int BRANCH_UNIT = 0;
    localparam int ALU_UNIT = 1;
    localparam int LS_UNIT = 2;

    // Adder path for everything that is not a bitwise op
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_XOR = 2'b01,
        ALU_OR = 2'b10,
        ALU_AND = 2'b11
    } alu_logic_op_t;

    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL = 1'b1
    } issue_state_t;

endpackage

`default_nettype wire

//--- hw/issue_stage_if.sv
////////////////////////////////////////////////////////////
// Issue-stage contents shared by the decoder and its consumers
////////////////////////////////////////////////////////////
`default_nettype none

interface issue_stage_if;
    import issue_pkg::*;

    logic stage_valid;
    unit_mask_t needed;
    logic uses_rs1;
    logic uses_rs2;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic is_store;
    id_t id;
    xlen_t pc;
    fn3_t fn3;

    // Capture strobe and stage clear, driven back from issue control
    logic load;
    logic flush;

    modport stage (
        output stage_valid, needed, uses_rs1, uses_rs2, rs1_addr, rs2_addr,
        output is_store, id, pc, fn3,
        input load, flush
    );

    modport sink (
        input stage_valid, needed, uses_rs1, uses_rs2, rs1_addr, rs2_addr,
        input is_store, id, pc, fn3,
        output load, flush
    );

endinterface

`default_nettype wire

//--- hw/operand_mux.sv
////////////////////////////////////////////////////////////
// Registered immediates and operand selection
// ALU inputs, branch offset and load-store offset
////////////////////////////////////////////////////////////
`default_nettype none

module operand_mux (
    input logic clk,

    input issue_pkg::instr_t decode_instruction,
    input issue_pkg::xlen_t decode_pc,

    issue_stage_if.sink stage,

    input issue_pkg::xlen_t rs1_data,
    input issue_pkg::xlen_t rs2_data,
    input logic rs2_busy,

    output issue_pkg::xlen_t alu_in1,
    output issue_pkg::xlen_t alu_in2,
    output logic alu_subtract,
    output issue_pkg::alu_logic_op_t alu_logic_op,
    output issue_pkg::pc_offset_t branch_pc_offset,
    output issue_pkg::ls_offset_t ls_offset,
    output logic ls_store,
    output logic ls_forward
);
    import issue_pkg::*;

    opcode_class_t opc;
    fn3_t fn3;
    logic arith_op;
    xlen_t pre_in1;
    xlen_t pre_in2;
    alu_logic_op_t logic_op;
    pc_offset_t pc_offset;

    xlen_t pre_in1_q;
    xlen_t pre_in2_q;
    logic rs1_use_regfile_q;
    logic rs2_use_regfile_q;

    assign opc = decode_instruction[6:2];
    assign fn3 = decode_instruction[14:12];
    assign arith_op = opc inside {OP_C, OP_IMM_C};

    ////////////////////////////////////////////////////////////
    // Decode-side immediates
    always_comb begin
        if (opc inside {LUI_C, AUIPC_C}) begin
            pre_in2 = {decode_instruction[31:12], 12'b0};
        end else if (opc inside {JAL_C, JALR_C}) begin
            pre_in2 = 32'd4;
        end else begin
            pre_in2 = {{20{decode_instruction[31]}}, decode_instruction[31:20]};
        end
        pre_in1 = (opc inside {AUIPC_C, JAL_C, JALR_C}) ? decode_pc : '0;
    end

    always_comb begin
        logic_op = ALU_ADD;
        if (arith_op) begin
            case (fn3)
                XOR_F3: logic_op = ALU_XOR;
                OR_F3: logic_op = ALU_OR;
                AND_F3: logic_op = ALU_AND;
                default: logic_op = ALU_ADD;
            endcase
        end
    end

    // JALR, JAL, then conditional branch
    always_comb begin
        if (opc == JALR_C) begin
            pc_offset = {{9{decode_instruction[31]}}, decode_instruction[31:20]};
        end else if (opc == JAL_C) begin
            pc_offset = {decode_instruction[31], decode_instruction[19:12],
                         decode_instruction[20], decode_instruction[30:21], 1'b0};
        end else begin
            pc_offset = {{8{decode_instruction[31]}}, decode_instruction[31],
                         decode_instruction[7], decode_instruction[30:25],
                         decode_instruction[11:8], 1'b0};
        end
    end

    ////////////////////////////////////////////////////////////
    // Captured with the stage
    always_ff @(posedge clk) begin
        if (stage.load) begin
            pre_in1_q <= pre_in1;
            pre_in2_q <= pre_in2;
            rs1_use_regfile_q <= !(opc inside {LUI_C, AUIPC_C, JAL_C, JALR_C});
            rs2_use_regfile_q <= !(opc inside {LUI_C, AUIPC_C, JAL_C, JALR_C, OP_IMM_C});
            // SUB, SLT[I] and SLTU[I]
            alu_subtract <= arith_op && ((fn3 inside {SLT_F3, SLTU_F3}) ||
                ((opc == OP_C) && (fn3 == ADD_SUB_F3) && decode_instruction[30]));
            alu_logic_op <= logic_op;
            branch_pc_offset <= pc_offset;
            ls_offset <= (opc == STORE_C) ?
                {decode_instruction[31:25], decode_instruction[11:7]} :
                decode_instruction[31:20];
        end
    end

    assign alu_in1 = rs1_use_regfile_q ? rs1_data : pre_in1_q;
    assign alu_in2 = rs2_use_regfile_q ? rs2_data : pre_in2_q;

    assign ls_store = stage.is_store;
    assign ls_forward = stage.stage_valid && stage.is_store && rs2_busy;

endmodule

`default_nettype wire

//--- hw/unit_issue_port.sv
////////////////////////////////////////////////////////////
// Issue check for one execution unit
////////////////////////////////////////////////////////////
`default_nettype none

module unit_issue_port #(
    parameter int UNIT_INDEX = 0,
    parameter bit NEEDS_RS2 = 1'b1
) (
    input logic clk,
    input logic rst,

    issue_stage_if.sink stage,

    input logic ready,
    input logic rs1_busy,
    input logic rs2_busy,

    output logic blocks
);
    import issue_pkg::*;

    logic needed;
    logic rs1_wait;
    logic rs2_wait;
    logic request;

    assign needed = stage.needed[UNIT_INDEX];

    assign rs1_wait = stage.uses_rs1 && rs1_busy;
    // Load-store forwards rs2 itself, so it waits on rs1 only
    assign rs2_wait = NEEDS_RS2 && stage.uses_rs2 && rs2_busy;

    assign blocks = needed && (!ready || rs1_wait || rs2_wait);

    // A full stage loads again only when it issues
    assign request = stage.stage_valid && stage.load && needed;

    ////////////////////////////////////////////////////////////
    // Assertions
    request_to_ready_unit: assert property (@(posedge clk) disable iff (rst)
        request |-> ready)
        else $error("request sent to unit %0d while not ready", UNIT_INDEX);

    blocked_stage_holds: assert property (@(posedge clk) disable iff (rst)
        (stage.stage_valid && blocks && !stage.flush) |=>
            (stage.stage_valid && $stable(stage.id)))
        else $error("stage changed while unit %0d blocked", UNIT_INDEX);

endmodule

`default_nettype wire

//--- src.f
hw/issue_pkg.sv
hw/issue_stage_if.sv
hw/decode_stage.sv
hw/unit_issue_port.sv
hw/issue_control.sv
hw/operand_mux.sv
hw/decode_issue_top.sv
test/tb_decode_issue.sv

//--- test/tb_decode_issue.sv
////////////////////////////////////////////////////////////
// Testbench for the decode and issue stage
// Random instruction stream, unit and register file models,
// reference queue of transferred instructions, assertions
////////////////////////////////////////////////////////////
`default_nettype none

module tb_decode_issue;
    import issue_pkg::*;

    localparam int NUM_INSTR = 400;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES = RESET_CYCLES + 40 * NUM_INSTR;

    typedef struct packed {
        instr_t instr;
        id_t id;
        xlen_t pc;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    logic decode_valid;
    instr_t decode_instruction;
    xlen_t decode_pc;
    id_t decode_id;
    logic decode_advance;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic rs1_busy;
    logic rs2_busy;
    unit_mask_t unit_ready;
    unit_mask_t new_request;
    id_t issue_id;
    logic instruction_issued;
    xlen_t issue_pc;
    fn3_t issue_fn3;
    logic issue_hold;
    logic flush;
    xlen_t alu_in1;
    xlen_t alu_in2;
    logic alu_subtract;
    alu_logic_op_t alu_logic_op;
    pc_offset_t branch_pc_offset;
    ls_offset_t ls_offset;
    logic ls_store;
    logic ls_forward;

    logic [31:0] lfsr_state;
    entry_t pending[$];
    entry_t cur;
    logic have_cur = 1'b0;
    logic transferred = 1'b0;
    int errors = 0;
    int built = 0;
    int done = 0;
    int issued = 0;
    int flushed = 0;
    int cycles = 0;
    int ready_stalls = 0;
    int hold_stalls = 0;
    int busy_stalls = 0;
    int forwards = 0;
    int bare_retires = 0;

    decode_issue_top dut_i (.*);

    always #10 clk = ~clk;

    // Register file model with data that depends only on the address
    function automatic xlen_t reg_value(input reg_addr_t a);
        return {3'b101, a, ~a, a, ~a, a, 4'h3};
    endfunction

    assign rs1_data = reg_value(rs1_addr);
    assign rs2_data = reg_value(rs2_addr);

    ////////////////////////////////////////////////////////////
    // Random source
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic entry_t make_entry();
        entry_t e;
        logic [3:0] kind;
        logic [31:0] pc_bits;
        opcode_class_t cls;
        e.instr = take_bits(32);
        kind = 4'(take_bits(4) % 32'd13);
        case (kind)
            4'd0: cls = LUI_C;
            4'd1: cls = AUIPC_C;
            4'd2: cls = JAL_C;
            4'd3: cls = JALR_C;
            4'd4: cls = BRANCH_C;
            4'd5: cls = LOAD_C;
            4'd6: cls = STORE_C;
            4'd7: cls = OP_IMM_C;
            4'd8, 4'd9: cls = OP_C;
            4'd10: cls = FENCE_C;
            4'd11: cls = SYSTEM_C;
            // AMO opcode that no kept unit takes
            default: cls = 5'b01011;
        endcase
        e.instr[6:0] = {cls, 2'b11};
        // Kind 9 is a multiply or divide
        if (cls == OP_C) begin
            e.instr[25] = (kind == 4'd9);
        end
        e.id = id_t'(built);
        pc_bits = take_bits(30);
        e.pc = {pc_bits[29:0], 2'b00};
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Expected decode from the ISA rules
    function automatic unit_mask_t unit_mask_of(input instr_t i);
        unit_mask_t m;
        opcode_class_t c;
        c = i[6:2];
        m = '0;
        m[BRANCH_UNIT] = (c == BRANCH_C) || (c == JAL_C) || (c == JALR_C);
        m[ALU_UNIT] = ((c == OP_C) && !i[25]) || (c == OP_IMM_C) || (c == AUIPC_C) ||
                      (c == LUI_C) || (c == JAL_C) || (c == JALR_C);
        m[LS_UNIT] = (c == LOAD_C) || (c == STORE_C);
        return m;
    endfunction

    function automatic logic reads_rs1(input instr_t i);
        return !(i[6:2] inside {LUI_C, AUIPC_C, JAL_C});
    endfunction

    function automatic logic reads_rs2(input instr_t i);
        return i[6:2] inside {BRANCH_C, STORE_C, OP_C};
    endfunction

    function automatic xlen_t alu_in1_of(input entry_t e);
        if (e.instr[6:2] == LUI_C) begin
            return '0;
        end
        if (e.instr[6:2] inside {AUIPC_C, JAL_C, JALR_C}) begin
            return e.pc;
        end
        return reg_value(e.instr[19:15]);
    endfunction

    function automatic xlen_t alu_in2_of(input instr_t i);
        case (i[6:2])
            LUI_C, AUIPC_C: return {i[31:12], 12'h000};
            JAL_C, JALR_C: return 32'd4;
            OP_IMM_C: return xlen_t'($signed(i[31:20]));
            default: return reg_value(i[24:20]);
        endcase
    endfunction

    function automatic logic subtract_of(input instr_t i);
        if (!(i[6:2] inside {OP_C, OP_IMM_C})) begin
            return 1'b0;
        end
        return (i[14:12] == 3'b010) || (i[14:12] == 3'b011) ||
               ((i[6:2] == OP_C) && (i[14:12] == 3'b000) && i[30]);
    endfunction

    function automatic alu_logic_op_t logic_op_of(input instr_t i);
        if (!(i[6:2] inside {OP_C, OP_IMM_C})) begin
            return ALU_ADD;
        end
        case (i[14:12])
            3'b100: return ALU_XOR;
            3'b110: return ALU_OR;
            3'b111: return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic pc_offset_t pc_offset_of(input instr_t i);
        if (i[6:2] == JALR_C) begin
            return pc_offset_t'($signed(i[31:20]));
        end
        if (i[6:2] == JAL_C) begin
            return {i[31], i[19:12], i[20], i[30:21], 1'b0};
        end
        return pc_offset_t'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
    endfunction

    function automatic ls_offset_t ls_offset_of(input instr_t i);
        return (i[6:2] == STORE_C) ? {i[31:25], i[11:7]} : i[31:20];
    endfunction

    ////////////////////////////////////////////////////////////
    // Reporting
    task automatic flag_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_test(input string name, input int first_error);
        $display("test %s: %0d errors", name, errors - first_error);
    endtask

    task automatic require_reached(input string what, input int count);
        if (count == 0) begin
            $display("the stimulus never produced %s", what);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks and reference queue sampled mid-cycle
    always @(negedge clk) begin : check_cycle
        entry_t head;
        logic have;
        unit_mask_t need;
        logic unit_wait;
        logic op_wait;
        logic exp_issue;
        logic exp_advance;
        if (rst) begin
            assert (new_request == '0 && !instruction_issued)
                else flag_mismatch("request or issue while in reset");
            transferred = 1'b0;
        end else begin
            have = (pending.size() != 0);
            head = '0;
            if (have) begin
                head = pending[0];
            end
            need = have ? unit_mask_of(head.instr) : '0;
            unit_wait = (need & ~unit_ready) != '0;
            // Load-store takes rs2 by forwarding
            op_wait = (need != '0) && ((reads_rs1(head.instr) && rs1_busy) ||
                      (reads_rs2(head.instr) && rs2_busy &&
                       (need[BRANCH_UNIT] || need[ALU_UNIT])));
            exp_issue = have && !issue_hold && !flush && !unit_wait && !op_wait;
            exp_advance = decode_valid && !issue_hold && !flush && (!have || exp_issue);

            assert (instruction_issued == exp_issue)
                else flag_mismatch($sformatf("issued %0b, expected %0b",
                                             instruction_issued, exp_issue));
            assert (new_request == (exp_issue ? need : '0))
                else flag_mismatch($sformatf("request %b, expected %b", new_request,
                                             exp_issue ? need : '0));
            assert (decode_advance == exp_advance)
                else flag_mismatch($sformatf("advance %0b, expected %0b",
                                             decode_advance, exp_advance));
            if (exp_issue) begin
                assert (issue_id == head.id)
                    else flag_mismatch($sformatf("issue id %0h, expected %0h",
                                                 issue_id, head.id));
                assert (issue_pc == head.pc)
                    else flag_mismatch($sformatf("issue pc %h, expected %h",
                                                 issue_pc, head.pc));
                assert (issue_fn3 == head.instr[14:12])
                    else flag_mismatch($sformatf("issue fn3 %b, expected %b",
                                                 issue_fn3, head.instr[14:12]));
            end
            if (exp_issue && need[ALU_UNIT]) begin
                assert (alu_in1 == alu_in1_of(head))
                    else flag_mismatch($sformatf("alu_in1 %h, expected %h",
                                                 alu_in1, alu_in1_of(head)));
                assert (alu_in2 == alu_in2_of(head.instr))
                    else flag_mismatch($sformatf("alu_in2 %h, expected %h",
                                                 alu_in2, alu_in2_of(head.instr)));
                assert (alu_subtract == subtract_of(head.instr))
                    else flag_mismatch("alu_subtract wrong");
                assert (alu_logic_op == logic_op_of(head.instr))
                    else flag_mismatch("alu_logic_op wrong");
            end
            if (exp_issue && need[BRANCH_UNIT]) begin
                assert (branch_pc_offset == pc_offset_of(head.instr))
                    else flag_mismatch($sformatf("branch offset %h, expected %h",
                        branch_pc_offset, pc_offset_of(head.instr)));
            end
            if (exp_issue && need[LS_UNIT]) begin
                assert (ls_offset == ls_offset_of(head.instr))
                    else flag_mismatch($sformatf("ls_offset %h, expected %h",
                        ls_offset, ls_offset_of(head.instr)));
                assert (ls_store == (head.instr[6:2] == STORE_C))
                    else flag_mismatch("ls_store wrong");
                assert (ls_forward == ((head.instr[6:2] == STORE_C) && rs2_busy))
                    else flag_mismatch("ls_forward wrong");
            end

            // Reach counters for the back-pressure cases
            if (have && issue_hold) begin
                hold_stalls++;
            end
            if (have && !issue_hold && !flush && unit_wait) begin
                ready_stalls++;
            end
            if (have && !issue_hold && !flush && op_wait) begin
                busy_stalls++;
            end
            if (exp_issue && need[LS_UNIT] && head.instr[6:2] == STORE_C && rs2_busy) begin
                forwards++;
            end
            if (exp_issue && need == '0) begin
                bare_retires++;
            end

            // Stage update at the coming edge
            if (flush && have) begin
                pending.delete();
                flushed++;
                done++;
            end else if (exp_issue) begin
                void'(pending.pop_front());
                issued++;
                done++;
            end
            if (exp_advance) begin
                pending.push_back({decode_instruction, decode_id, decode_pc});
            end
            transferred = exp_advance;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    task automatic drive_cycle();
        int u;
        if (transferred) begin
            have_cur = 1'b0;
        end
        if (!have_cur && built < NUM_INSTR) begin
            cur = make_entry();
            built++;
            have_cur = 1'b1;
        end
        decode_valid = have_cur && (take_bits(2) != 0);
        decode_instruction = cur.instr;
        decode_id = cur.id;
        decode_pc = cur.pc;
        for (u = 0; u < NUM_UNITS; u++) begin
            unit_ready[u] = (take_bits(2) != 0);
        end
        rs1_busy = (take_bits(2) == 0);
        rs2_busy = (take_bits(2) == 0);
        issue_hold = (take_bits(3) == 0);
        flush = (take_bits(5) == 0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int first;
        lfsr_state = 32'ha1f674ee;
        cur = '0;
        rst = 1'b1;
        decode_valid = 1'b0;
        decode_instruction = '0;
        decode_pc = '0;
        decode_id = '0;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        unit_ready = '1;
        issue_hold = 1'b0;
        flush = 1'b0;
        first = 0;

        // Reset and then a few idle cycles with nothing offered
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        report_test("reset", first);

        first = errors;
        while (done < NUM_INSTR) begin
            @(posedge clk);
            #2;
            drive_cycle();
        end
        report_test("random issue", first);

        first = errors;
        require_reached("a stall on a unit that was not ready", ready_stalls);
        require_reached("a stall on issue_hold", hold_stalls);
        require_reached("a stall on a busy operand", busy_stalls);
        require_reached("a store issued with rs2 busy", forwards);
        require_reached("a retire with no unit request", bare_retires);
        require_reached("a flush of a full stage", flushed);
        report_test("stall coverage", first);

        $display("transferred %0d, issued %0d, flushed %0d, errors %0d",
                 built, issued, flushed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
